// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int DATA_W = 32;
    localparam int REG_AW = 5;
    localparam int INST_W = 32;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_PREF    = 6'b110011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_SYNC = 6'b001111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_MOVZ, ALU_MOVN
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE
    } alusel_e;

endpackage

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          we_i,
    input  wire [mips_pkg::REG_AW-1:0]   waddr_i,
    input  wire [mips_pkg::DATA_W-1:0]   wdata_i,
    input  wire [mips_pkg::REG_AW-1:0]   raddr1_i,
    input  wire [mips_pkg::REG_AW-1:0]   raddr2_i,
    output logic [mips_pkg::DATA_W-1:0]  rdata1_o,
    output logic [mips_pkg::DATA_W-1:0]  rdata2_o
);

    localparam int DEPTH = 1 << mips_pkg::REG_AW;

    logic [mips_pkg::DATA_W-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i; // r0 stays zero
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

// File: logic/operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sel (
    input  wire                          read_i,
    input  wire [mips_pkg::REG_AW-1:0]   addr_i,
    input  wire [mips_pkg::DATA_W-1:0]   rf_data_i,
    input  wire [mips_pkg::DATA_W-1:0]   imm_i,
    input  wire                          ex_we_i,
    input  wire [mips_pkg::REG_AW-1:0]   ex_wd_i,
    input  wire [mips_pkg::DATA_W-1:0]   ex_data_i,
    input  wire                          mem_we_i,
    input  wire [mips_pkg::REG_AW-1:0]   mem_wd_i,
    input  wire [mips_pkg::DATA_W-1:0]   mem_data_i,
    output logic [mips_pkg::DATA_W-1:0]  operand_o
);

    // Youngest producer wins
    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_we_i && (ex_wd_i == addr_i)) begin
            operand_o = ex_data_i;
        end else if (mem_we_i && (mem_wd_i == addr_i)) begin
            operand_o = mem_data_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/id_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module id_ctrl (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          inst_valid_i,
    input  wire [mips_pkg::INST_W-1:0]   inst_i,
    input  wire                          wb_ready_i,
    output logic                         inst_ready_o,
    output logic                         advance_o,
    output logic                         reg1_read_o,
    output logic                         reg2_read_o,
    output logic [mips_pkg::REG_AW-1:0]  reg1_addr_o,
    output logic [mips_pkg::REG_AW-1:0]  reg2_addr_o,
    output logic [mips_pkg::DATA_W-1:0]  imm_o,
    output mips_pkg::aluop_e             aluop_o,
    output mips_pkg::alusel_e            alusel_o,
    output logic [mips_pkg::REG_AW-1:0]  wd_o,
    output logic                         wreg_o,
    output logic                         invalid_o,
    output logic                         ex_valid_o,
    output logic                         mem_valid_o
);

    mips_pkg::opcode_e op;
    mips_pkg::funct_e  fn;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [4:0]        shamt;
    logic              is_imm;
    logic              wr;
    logic              valid_enc;

    assign op     = mips_pkg::opcode_e'(inst_i[31:26]);
    assign fn     = mips_pkg::funct_e'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign is_imm = (inst_i[31:29] == 3'b001); // ADDI through LUI

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    always_comb begin
        aluop_o     = mips_pkg::ALU_NOP;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        wd_o        = rd;
        wr          = 1'b0;
        valid_enc   = 1'b0;
        imm_o       = '0;
        if (is_imm) begin
            reg1_read_o = (op != mips_pkg::OP_LUI);
            wd_o        = rt;
            wr          = 1'b1;
            valid_enc   = 1'b1;
            if (op == mips_pkg::OP_LUI) begin
                imm_o = {inst_i[15:0], 16'h0};
            end else if (inst_i[28]) begin
                imm_o = {16'h0, inst_i[15:0]}; // Logic immediates zero-extend
            end else begin
                imm_o = {{16{inst_i[15]}}, inst_i[15:0]};
            end
        end
        case (op)
            mips_pkg::OP_SPECIAL: begin
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                wr          = 1'b1;
                valid_enc   = (shamt == 5'd0);
                case (fn)
                    mips_pkg::FN_OR:   aluop_o = mips_pkg::ALU_OR;
                    mips_pkg::FN_AND:  aluop_o = mips_pkg::ALU_AND;
                    mips_pkg::FN_XOR:  aluop_o = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  aluop_o = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLLV: aluop_o = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRLV: aluop_o = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRAV: aluop_o = mips_pkg::ALU_SRA;
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU: aluop_o = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU: aluop_o = mips_pkg::ALU_SUB;
                    mips_pkg::FN_SLT:  aluop_o = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: aluop_o = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_MOVZ: aluop_o = mips_pkg::ALU_MOVZ; // Write enable settled in ALU
                    mips_pkg::FN_MOVN: aluop_o = mips_pkg::ALU_MOVN;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                        aluop_o     = (fn == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL :
                                      (fn == mips_pkg::FN_SRL) ? mips_pkg::ALU_SRL :
                                                                 mips_pkg::ALU_SRA;
                        reg1_read_o = 1'b0; // Shift amount comes in as the immediate
                        imm_o       = {27'd0, shamt};
                        valid_enc   = (rs == 5'd0);
                    end
                    mips_pkg::FN_SYNC: begin
                        reg1_read_o = 1'b0;
                        reg2_read_o = 1'b0;
                        wr          = 1'b0;
                        valid_enc   = 1'b1;
                    end
                    default: begin
                        wr        = 1'b0;
                        valid_enc = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_PREF:              valid_enc = 1'b1;
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: aluop_o = mips_pkg::ALU_OR;
            mips_pkg::OP_ANDI:              aluop_o = mips_pkg::ALU_AND;
            mips_pkg::OP_XORI:              aluop_o = mips_pkg::ALU_XOR;
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: aluop_o = mips_pkg::ALU_ADD;
            mips_pkg::OP_SLTI:              aluop_o = mips_pkg::ALU_SLT;
            mips_pkg::OP_SLTIU:             aluop_o = mips_pkg::ALU_SLTU;
            default: ;
        endcase
    end

    always_comb begin
        case (aluop_o)
            mips_pkg::ALU_OR, mips_pkg::ALU_AND,
            mips_pkg::ALU_XOR, mips_pkg::ALU_NOR:   alusel_o = mips_pkg::SEL_LOGIC;
            mips_pkg::ALU_SLL, mips_pkg::ALU_SRL,
            mips_pkg::ALU_SRA:                      alusel_o = mips_pkg::SEL_SHIFT;
            mips_pkg::ALU_ADD, mips_pkg::ALU_SUB,
            mips_pkg::ALU_SLT, mips_pkg::ALU_SLTU:  alusel_o = mips_pkg::SEL_ARITH;
            mips_pkg::ALU_MOVZ, mips_pkg::ALU_MOVN: alusel_o = mips_pkg::SEL_MOVE;
            default:                                alusel_o = mips_pkg::SEL_NOP;
        endcase
    end

    assign wreg_o    = wr & valid_enc & (wd_o != 5'd0); // Invalid encodings and r0 never write
    assign invalid_o = ~valid_enc;

    // Stall only when the memory stage is full and writeback is blocked
    assign advance_o    = ~mem_valid_o | wb_ready_i;
    assign inst_ready_o = advance_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o  <= 1'b0;
            mem_valid_o <= 1'b0;
        end else if (advance_o) begin
            ex_valid_o  <= inst_valid_i;
            mem_valid_o <= ex_valid_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          advance_i,
    input  wire                          ex_valid_i,
    input  wire                          mem_valid_i,
    input  wire mips_pkg::aluop_e        aluop_i,
    input  wire mips_pkg::alusel_e       alusel_i,
    input  wire [mips_pkg::REG_AW-1:0]   wd_i,
    input  wire                          wreg_i,
    input  wire                          invalid_i,
    input  wire [mips_pkg::DATA_W-1:0]   reg1_i,
    input  wire [mips_pkg::DATA_W-1:0]   reg2_i,
    output logic                         ex_we_o,
    output logic [mips_pkg::REG_AW-1:0]  ex_wd_o,
    output logic [mips_pkg::DATA_W-1:0]  ex_data_o,
    output logic                         mem_we_o,
    output logic [mips_pkg::REG_AW-1:0]  mem_wd_o,
    output logic [mips_pkg::DATA_W-1:0]  mem_data_o,
    output logic                         wb_invalid_o
);

    mips_pkg::aluop_e            ex_aluop;
    mips_pkg::alusel_e           ex_alusel;
    logic                        ex_wreg;
    logic                        ex_invalid;
    logic [mips_pkg::DATA_W-1:0] ex_reg1;
    logic [mips_pkg::DATA_W-1:0] ex_reg2;
    logic [mips_pkg::DATA_W-1:0] logic_res;
    logic [mips_pkg::DATA_W-1:0] shift_res;
    logic [mips_pkg::DATA_W-1:0] arith_res;
    logic                        cond_we;
    logic                        ex_we_raw;
    logic                        mem_we;
    logic                        mem_invalid;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_wreg    <= 1'b0;
            ex_invalid <= 1'b0;
        end else if (advance_i) begin
            ex_wreg    <= wreg_i;
            ex_invalid <= invalid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            ex_aluop  <= aluop_i;
            ex_alusel <= alusel_i;
            ex_wd_o   <= wd_i;
            ex_reg1   <= reg1_i;
            ex_reg2   <= reg2_i;
        end
    end

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        arith_res = '0;
        case (ex_aluop)
            mips_pkg::ALU_OR:   logic_res = ex_reg1 | ex_reg2;
            mips_pkg::ALU_AND:  logic_res = ex_reg1 & ex_reg2;
            mips_pkg::ALU_XOR:  logic_res = ex_reg1 ^ ex_reg2;
            mips_pkg::ALU_NOR:  logic_res = ~(ex_reg1 | ex_reg2);
            mips_pkg::ALU_SLL:  shift_res = ex_reg2 << ex_reg1[4:0];
            mips_pkg::ALU_SRL:  shift_res = ex_reg2 >> ex_reg1[4:0];
            mips_pkg::ALU_SRA:  shift_res = $unsigned($signed(ex_reg2) >>> ex_reg1[4:0]);
            mips_pkg::ALU_ADD:  arith_res = ex_reg1 + ex_reg2; // No overflow trap
            mips_pkg::ALU_SUB:  arith_res = ex_reg1 - ex_reg2;
            mips_pkg::ALU_SLT:  arith_res = {31'd0, $signed(ex_reg1) < $signed(ex_reg2)};
            mips_pkg::ALU_SLTU: arith_res = {31'd0, ex_reg1 < ex_reg2};
            default: ;
        endcase
    end

    always_comb begin
        case (ex_alusel)
            mips_pkg::SEL_LOGIC: ex_data_o = logic_res;
            mips_pkg::SEL_SHIFT: ex_data_o = shift_res;
            mips_pkg::SEL_ARITH: ex_data_o = arith_res;
            mips_pkg::SEL_MOVE:  ex_data_o = ex_reg1;
            default:             ex_data_o = '0;
        endcase
    end

    // MOVZ/MOVN write only when the forwarded rt matches the condition
    assign cond_we   = (ex_aluop == mips_pkg::ALU_MOVZ) ? (ex_reg2 == '0) :
                       (ex_aluop == mips_pkg::ALU_MOVN) ? (ex_reg2 != '0) : 1'b1;
    assign ex_we_raw = ex_wreg & cond_we;
    assign ex_we_o   = ex_valid_i & ex_we_raw;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_we      <= 1'b0;
            mem_invalid <= 1'b0;
        end else if (advance_i) begin
            mem_we      <= ex_we_raw;
            mem_invalid <= ex_invalid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            mem_wd_o   <= ex_wd_o;
            mem_data_o <= ex_data_o;
        end
    end

    assign mem_we_o     = mem_valid_i & mem_we;
    assign wb_invalid_o = mem_valid_i & mem_invalid;

endmodule

`default_nettype wire

// File: logic/mips_id_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_id_core (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          inst_valid_i,
    input  wire [mips_pkg::INST_W-1:0]   inst_i,
    output logic                         inst_ready_o,
    output logic                         wb_valid_o,
    input  wire                          wb_ready_i,
    output logic                         wb_we_o,
    output logic [mips_pkg::REG_AW-1:0]  wb_addr_o,
    output logic [mips_pkg::DATA_W-1:0]  wb_data_o,
    output logic                         wb_invalid_o
);

    logic                        advance;
    logic                        reg1_read;
    logic                        reg2_read;
    logic [mips_pkg::REG_AW-1:0] reg1_addr;
    logic [mips_pkg::REG_AW-1:0] reg2_addr;
    logic [mips_pkg::DATA_W-1:0] imm;
    mips_pkg::aluop_e            aluop;
    mips_pkg::alusel_e           alusel;
    logic [mips_pkg::REG_AW-1:0] wd;
    logic                        wreg;
    logic                        invalid;
    logic                        ex_valid;
    logic                        mem_valid;
    logic [mips_pkg::DATA_W-1:0] rf_data1;
    logic [mips_pkg::DATA_W-1:0] rf_data2;
    logic [mips_pkg::DATA_W-1:0] reg1;
    logic [mips_pkg::DATA_W-1:0] reg2;
    logic                        ex_we;
    logic [mips_pkg::REG_AW-1:0] ex_wd;
    logic [mips_pkg::DATA_W-1:0] ex_data;
    logic                        rf_we;

    id_ctrl u_id_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_ready_i   (wb_ready_i),
        .inst_ready_o (inst_ready_o),
        .advance_o    (advance),
        .reg1_read_o  (reg1_read),
        .reg2_read_o  (reg2_read),
        .reg1_addr_o  (reg1_addr),
        .reg2_addr_o  (reg2_addr),
        .imm_o        (imm),
        .aluop_o      (aluop),
        .alusel_o     (alusel),
        .wd_o         (wd),
        .wreg_o       (wreg),
        .invalid_o    (invalid),
        .ex_valid_o   (ex_valid),
        .mem_valid_o  (mem_valid)
    );

    // Commit on the writeback handshake
    assign rf_we = wb_valid_o & wb_ready_i & wb_we_o;

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (rf_we),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    operand_sel u_operand_sel_1 (
        .read_i     (reg1_read),
        .addr_i     (reg1_addr),
        .rf_data_i  (rf_data1),
        .imm_i      (imm),
        .ex_we_i    (ex_we),
        .ex_wd_i    (ex_wd),
        .ex_data_i  (ex_data),
        .mem_we_i   (wb_we_o),
        .mem_wd_i   (wb_addr_o),
        .mem_data_i (wb_data_o),
        .operand_o  (reg1)
    );

    operand_sel u_operand_sel_2 (
        .read_i     (reg2_read),
        .addr_i     (reg2_addr),
        .rf_data_i  (rf_data2),
        .imm_i      (imm),
        .ex_we_i    (ex_we),
        .ex_wd_i    (ex_wd),
        .ex_data_i  (ex_data),
        .mem_we_i   (wb_we_o),
        .mem_wd_i   (wb_addr_o),
        .mem_data_i (wb_data_o),
        .operand_o  (reg2)
    );

    exec_pipe u_exec_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .advance_i    (advance),
        .ex_valid_i   (ex_valid),
        .mem_valid_i  (mem_valid),
        .aluop_i      (aluop),
        .alusel_i     (alusel),
        .wd_i         (wd),
        .wreg_i       (wreg),
        .invalid_i    (invalid),
        .reg1_i       (reg1),
        .reg2_i       (reg2),
        .ex_we_o      (ex_we),
        .ex_wd_o      (ex_wd),
        .ex_data_o    (ex_data),
        .mem_we_o     (wb_we_o),
        .mem_wd_o     (wb_addr_o),
        .mem_data_o   (wb_data_o),
        .wb_invalid_o (wb_invalid_o)
    );

    assign wb_valid_o = mem_valid;

endmodule

`default_nettype wire

// File: sim/tb_mips_id_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_id_core;

    localparam int NUM_INSTS = 265;
    localparam int TIMEOUT   = 4 * NUM_INSTS + 200;

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        inst_ready_o;
    logic        wb_valid_o;
    logic        wb_ready_i;
    logic        wb_we_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;
    logic        wb_invalid_o;

    logic        gap_mode;
    logic [31:0] model_regs [32];
    logic [38:0] exp_q [$]; // {invalid, we, addr, data}
    int          errors;
    int          issued_count;
    int          wb_count;
    int          cycles;

    mips_id_core u_mips_id_core (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_invalid_o (wb_invalid_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            wb_ready_i <= 1'b0;
        end else if (gap_mode) begin
            wb_ready_i <= (($urandom % 3) != 0);
        end else begin
            wb_ready_i <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            check_writeback();
        end
    end

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pick_funct(input int i);
        case (i)
            0:       return mips_pkg::FN_OR;
            1:       return mips_pkg::FN_AND;
            2:       return mips_pkg::FN_XOR;
            3:       return mips_pkg::FN_NOR;
            4:       return mips_pkg::FN_ADD;
            5:       return mips_pkg::FN_ADDU;
            6:       return mips_pkg::FN_SUB;
            7:       return mips_pkg::FN_SUBU;
            8:       return mips_pkg::FN_SLT;
            9:       return mips_pkg::FN_SLTU;
            10:      return mips_pkg::FN_SLLV;
            11:      return mips_pkg::FN_SRLV;
            12:      return mips_pkg::FN_SRAV;
            13:      return mips_pkg::FN_MOVZ;
            default: return mips_pkg::FN_MOVN;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAIL %s got %0h expected %0h", name, got, exp);
    endtask

    // Architectural model updated one instruction at a time in issue order
    task automatic predict(input logic [31:0] inst);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zimm;
        logic [31:0] simm;
        logic [31:0] res;
        logic        we;
        logic        inv;
        logic        bad_field;
        op   = inst[31:26];
        fn   = inst[5:0];
        rs   = inst[25:21];
        rt   = inst[20:16];
        sh   = inst[10:6];
        a    = model_regs[rs];
        b    = model_regs[rt];
        zimm = {16'h0000, inst[15:0]};
        simm = {{16{inst[15]}}, inst[15:0]};
        dst  = inst[15:11];
        res  = '0;
        we   = 1'b1;
        inv  = 1'b0;
        bad_field = 1'b0;
        if (op != mips_pkg::OP_SPECIAL) dst = rt;
        case (op)
            mips_pkg::OP_SPECIAL: begin
                case (fn)
                    mips_pkg::FN_OR:   res = a | b;
                    mips_pkg::FN_AND:  res = a & b;
                    mips_pkg::FN_XOR:  res = a ^ b;
                    mips_pkg::FN_NOR:  res = ~(a | b);
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU: res = a + b;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU: res = a - b;
                    mips_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    mips_pkg::FN_SLTU: res = {31'd0, a < b};
                    mips_pkg::FN_SLL:  res = b << sh;
                    mips_pkg::FN_SRL:  res = b >> sh;
                    mips_pkg::FN_SRA:  res = $signed(b) >>> sh;
                    mips_pkg::FN_SLLV: res = b << a[4:0];
                    mips_pkg::FN_SRLV: res = b >> a[4:0];
                    mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                    mips_pkg::FN_MOVZ: begin
                        res = a;
                        we  = (b == '0);
                    end
                    mips_pkg::FN_MOVN: begin
                        res = a;
                        we  = (b != '0);
                    end
                    mips_pkg::FN_SYNC: we = 1'b0;
                    default: begin
                        we  = 1'b0;
                        inv = 1'b1;
                    end
                endcase
                // Reserved fields must be zero
                if ((fn == mips_pkg::FN_SLL) || (fn == mips_pkg::FN_SRL) ||
                    (fn == mips_pkg::FN_SRA)) begin
                    bad_field = (rs != 5'd0);
                end else begin
                    bad_field = (fn != mips_pkg::FN_SYNC) && (sh != 5'd0);
                end
                if (bad_field) begin
                    we  = 1'b0;
                    inv = 1'b1;
                end
            end
            mips_pkg::OP_ORI:   res = a | zimm;
            mips_pkg::OP_ANDI:  res = a & zimm;
            mips_pkg::OP_XORI:  res = a ^ zimm;
            mips_pkg::OP_LUI:   res = {inst[15:0], 16'h0000};
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: res = a + simm;
            mips_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
            mips_pkg::OP_SLTIU: res = {31'd0, a < simm};
            mips_pkg::OP_PREF:  we = 1'b0;
            default: begin
                we  = 1'b0;
                inv = 1'b1;
            end
        endcase
        if (dst == 5'd0) we = 1'b0; // r0 is never written
        if (we) model_regs[dst] = res;
        exp_q.push_back({inv, we, dst, res});
        issued_count++;
    endtask

    task automatic check_writeback();
        logic [38:0] e;
        wb_count++;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("Writeback seen while no instruction was outstanding");
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (wb_invalid_o == e[38])
                else report_mismatch("wb_invalid_o", wb_invalid_o, e[38]);
            assert (wb_we_o == e[37])
                else report_mismatch("wb_we_o", wb_we_o, e[37]);
            if (e[37]) begin
                assert (wb_addr_o == e[36:32])
                    else report_mismatch("wb_addr_o", wb_addr_o, e[36:32]);
                assert (wb_data_o == e[31:0])
                    else report_mismatch("wb_data_o", wb_data_o, e[31:0]);
            end
        end
    endtask

    // Called on a rising edge; returns on the edge of the transfer
    task automatic issue(input logic [31:0] inst);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        @(posedge clk);
        while (!inst_ready_o) @(posedge clk);
        predict(inst);
    endtask

    task automatic drain();
        inst_valid_i <= 1'b0;
        while (exp_q.size() > 0) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic check_reset();
        assert (wb_valid_o == 1'b0) else report_mismatch("wb_valid_o", wb_valid_o, 0);
        assert (inst_ready_o == 1'b1) else report_mismatch("inst_ready_o", inst_ready_o, 1);
    endtask

    task automatic test_immediates();
        logic [31:0] v;
        issue(encode_i(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234));
        issue(encode_i(mips_pkg::OP_LUI, 5'd0, 5'd2, 16'hdead));
        issue(encode_i(mips_pkg::OP_ORI, 5'd2, 5'd2, 16'hbeef));
        issue(encode_i(mips_pkg::OP_ANDI, 5'd2, 5'd3, 16'hff0f));
        issue(encode_i(mips_pkg::OP_XORI, 5'd1, 5'd4, 16'hffff));
        issue(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd5, 16'h8000)); // Negative result
        issue(encode_i(mips_pkg::OP_ADDI, 5'd5, 5'd6, 16'h7fff));
        issue(encode_i(mips_pkg::OP_SLTI, 5'd5, 5'd7, 16'h0001));
        issue(encode_i(mips_pkg::OP_SLTIU, 5'd1, 5'd8, 16'hffff));
        issue(encode_i(mips_pkg::OP_SLTIU, 5'd5, 5'd9, 16'h8001));
        for (int r = 10; r < 18; r++) begin
            v = $urandom;
            issue(encode_i(mips_pkg::OP_LUI, 5'd0, 5'(r), v[31:16]));
            issue(encode_i(mips_pkg::OP_ORI, 5'(r), 5'(r), v[15:0]));
        end
    endtask

    // Consumers at distance d and d+1 from the producer of r20
    task automatic test_forwarding();
        logic [5:0] fn;
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 13; k++) begin
                fn = pick_funct(k);
                issue(encode_r(fn, 5'(10 + k % 8), 5'(10 + (k + 3) % 8), 5'd20, 5'd0));
                for (int f = 1; f < d; f++) begin
                    issue(encode_i(mips_pkg::OP_ORI, 5'd0, 5'd25, 16'(f)));
                end
                issue(encode_r(fn, 5'd20, 5'd12, 5'd21, 5'd0));
                issue(encode_r(fn, 5'd13, 5'd20, 5'd22, 5'd0));
            end
        end
        issue(encode_r(mips_pkg::FN_SLL, 5'd0, 5'd20, 5'd23, 5'd4));
        issue(encode_r(mips_pkg::FN_SRL, 5'd0, 5'd23, 5'd23, 5'd7));
        issue(encode_r(mips_pkg::FN_SRA, 5'd0, 5'd14, 5'd24, 5'd31));
    endtask

    task automatic test_moves();
        issue(encode_r(mips_pkg::FN_ADDU, 5'd0, 5'd0, 5'd27, 5'd0));
        issue(encode_r(mips_pkg::FN_MOVZ, 5'd10, 5'd27, 5'd28, 5'd0)); // Forwarded zero
        issue(encode_r(mips_pkg::FN_MOVN, 5'd10, 5'd27, 5'd29, 5'd0));
        issue(encode_i(mips_pkg::OP_ORI, 5'd0, 5'd27, 16'h0005));
        issue(encode_r(mips_pkg::FN_MOVZ, 5'd11, 5'd27, 5'd28, 5'd0));
        issue(encode_r(mips_pkg::FN_MOVN, 5'd11, 5'd27, 5'd29, 5'd0));
        issue(encode_r(mips_pkg::FN_MOVZ, 5'd12, 5'd0, 5'd30, 5'd0));
        issue(encode_r(mips_pkg::FN_MOVN, 5'd13, 5'd0, 5'd30, 5'd0));
        issue(encode_r(mips_pkg::FN_OR, 5'd28, 5'd29, 5'd31, 5'd0));
        issue(encode_r(mips_pkg::FN_OR, 5'd31, 5'd30, 5'd31, 5'd0));
    endtask

    task automatic test_backpressure();
        logic [31:0] prog [60];
        int          fi;
        int          ra;
        int          rb;
        int          rw;
        for (int i = 0; i < 60; i++) begin
            fi = $urandom % 15;
            ra = 10 + $urandom % 13;
            rb = 10 + $urandom % 13;
            rw = 16 + $urandom % 9;
            prog[i] = encode_r(pick_funct(fi), 5'(ra), 5'(rb), 5'(rw), 5'd0);
        end
        gap_mode <= 1'b1;
        for (int i = 0; i < 60; i++) begin
            issue(prog[i]);
        end
        drain();
        gap_mode <= 1'b0;
    endtask

    task automatic test_no_write();
        issue(encode_i(6'h3f, 5'd10, 5'd11, 16'h1234)); // Unknown opcode
        issue(encode_r(6'h01, 5'd10, 5'd11, 5'd12, 5'd0)); // Unknown function
        issue(encode_r(mips_pkg::FN_OR, 5'd10, 5'd11, 5'd12, 5'd3)); // Nonzero shift field
        issue(encode_r(mips_pkg::FN_SLL, 5'd10, 5'd11, 5'd12, 5'd3)); // Nonzero rs on a shift
        issue(encode_r(mips_pkg::FN_SYNC, 5'd0, 5'd0, 5'd0, 5'd0));
        issue(encode_i(mips_pkg::OP_PREF, 5'd10, 5'd1, 16'h0000));
        issue(encode_i(mips_pkg::OP_ADDIU, 5'd10, 5'd0, 16'h0005));
        issue(encode_r(mips_pkg::FN_OR, 5'd10, 5'd11, 5'd0, 5'd0));
        issue(encode_r(mips_pkg::FN_OR, 5'd0, 5'd0, 5'd5, 5'd0));
        issue(encode_r(mips_pkg::FN_ADDU, 5'd0, 5'd10, 5'd6, 5'd0));
    endtask

    initial begin
        void'($urandom(32'hc24f_478a));
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_ready_i   = 1'b0;
        gap_mode     = 1'b0;
        errors       = 0;
        issued_count = 0;
        wb_count     = 0;
        cycles       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_reset();
        test_immediates();
        drain();
        test_forwarding();
        drain();
        test_moves();
        drain();
        test_backpressure();
        test_no_write();
        drain();
        assert (wb_count == issued_count) else begin
            errors++;
            $display("Writeback count does not match the number of accepted instructions");
        end
        $display("Errors: %0d, writebacks: %0d, instructions: %0d",
                 errors, wb_count, issued_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/mips_pkg.sv
logic/regfile.sv
logic/operand_sel.sv
logic/id_ctrl.sv
logic/exec_pipe.sv
logic/mips_id_core.sv
sim/tb_mips_id_core.sv
